//--- Makefile
TOP = fetch_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -j 0 --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

//--- bench/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int IDX_W = $clog2(`IMEM_DEPTH);

    logic          clk;
    logic          reset;
    logic          ds_allowin;
    br_bus_t       br_bus;
    logic          fs_bd;
    logic          flush;
    logic          fs_to_ds_valid;
    fs_to_ds_bus_t fs_to_ds_bus;

    // bench copy of the instruction memory
    word_t         imem [0:`IMEM_DEPTH-1];

    // reference model state, written by the monitor only
    addr_t         exp_pc = `IMEM_BASE;
    int            xfer_count = 0;
    logic          prev_hold = 1'b0;
    fs_to_ds_bus_t prev_bus;

    int            stall_left;

    fetch_unit DUT (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .fs_bd          (fs_bd),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(string what, fs_to_ds_bus_t actual, fs_to_ds_bus_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic report_timeout();
        $display("No instruction arrived within %0d cycles, stuck at %0t ns",
                 TIMEOUT_CYCLES, $time);
        abort_run();
    endtask

    // expected decode bus for a pc, from the exception and zeroing rules
    function automatic fs_to_ds_bus_t expected_bus(addr_t pc, logic flush_lvl, logic bd);
        addr_t     off;
        logic      ex;
        exc_code_t code;
        word_t     inst;
        off  = pc - `IMEM_BASE;
        ex   = 1'b1;
        inst = '0;
        if (pc[1:0] != 2'b00) begin
            // misaligned wins, even outside the window
            code = `EXC_ADEL;
        end else if (off >= 32'(`IMEM_DEPTH * 4)) begin
            code = `EXC_IBE;
        end else begin
            ex   = 1'b0;
            code = '0;
            inst = flush_lvl ? '0 : imem[off[IDX_W+1:2]];
        end
        return {ex, code, bd, inst, pc};
    endfunction

    // bd follows the input pin, so leave it out of hold checks
    function automatic fs_to_ds_bus_t without_bd(fs_to_ds_bus_t bus);
        fs_to_ds_bus_t masked;
        masked     = bus;
        masked[64] = 1'b0;
        return masked;
    endfunction

    // sample mid-cycle, inputs and outputs both settled
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            // stalled last cycle, nothing may move
            if (prev_hold) begin
                check_value("fs_to_ds_valid under stall", fs_to_ds_bus_t'(fs_to_ds_valid),
                            fs_to_ds_bus_t'(1'b1));
                if (!flush) begin
                    check_value("bus under stall", without_bd(fs_to_ds_bus),
                                without_bd(prev_bus));
                end
            end
            if (fs_to_ds_valid && ds_allowin) begin
                check_value("transferred bus", fs_to_ds_bus,
                            expected_bus(exp_pc, flush, fs_bd));
                exp_pc = exp_pc + 32'd4;
                xfer_count++;
            end
            // redirect steers whatever comes after this cycle
            if (flush) begin
                exp_pc = `EXC_VECTOR;
            end else if (br_bus[`BR_BUS_WD-1]) begin
                exp_pc = br_bus[31:0];
            end
            prev_hold = fs_to_ds_valid && !ds_allowin && !flush;
            prev_bus  = fs_to_ds_bus;
        end
    end

    // one cycle of random traffic
    // branches only go out while decode accepts
    task automatic drive_random_cycle(int stall_pct, int br_pct);
        addr_t target;
        target = `IMEM_BASE + (($urandom % `IMEM_DEPTH) << 2);
        flush  <= 1'b0;
        fs_bd  <= 1'($urandom % 2);
        br_bus <= '0;
        if (stall_left > 0) begin
            stall_left--;
            ds_allowin <= 1'b0;
        end else if ($urandom % 100 < stall_pct) begin
            stall_left = $urandom_range(5, 0);
            ds_allowin <= 1'b0;
        end else begin
            ds_allowin <= 1'b1;
            if ($urandom % 100 < br_pct) begin
                br_bus <= {1'b1, target};
            end
        end
    endtask

    task automatic run_traffic(int n, int stall_pct, int br_pct);
        int goal;
        int seen;
        int idle;
        goal = xfer_count + n;
        seen = xfer_count;
        idle = 0;
        while (xfer_count < goal) begin
            @(posedge clk);
            drive_random_cycle(stall_pct, br_pct);
            if (xfer_count != seen) begin
                seen = xfer_count;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > TIMEOUT_CYCLES) begin
                report_timeout();
            end
        end
    endtask

    // one-cycle branch or flush, then wait until its target is transferred
    task automatic redirect_to(addr_t target, logic use_flush);
        int idle;
        @(posedge clk);
        fs_bd <= 1'b1;
        if (use_flush) begin
            // flush must win even with decode stalled
            ds_allowin <= 1'($urandom % 2);
            flush      <= 1'b1;
            br_bus     <= '0;
        end else begin
            ds_allowin <= 1'b1;
            flush      <= 1'b0;
            br_bus     <= {1'b1, target};
        end
        @(posedge clk);
        ds_allowin <= 1'b1;
        flush      <= 1'b0;
        br_bus     <= '0;
        fs_bd      <= 1'b0;
        idle = 0;
        while (exp_pc == target) begin
            @(posedge clk);
            idle++;
            if (idle > TIMEOUT_CYCLES) begin
                report_timeout();
            end
        end
    endtask

    initial begin
        void'($urandom(32'hcd44_31c0));
        clk        = 1'b0;
        reset      = 1'b1;
        ds_allowin = 1'b0;
        br_bus     = '0;
        fs_bd      = 1'b0;
        flush      = 1'b0;
        stall_left = 0;
        $readmemh("source/imem_init.hex", imem);

        // ten cycles of reset, valid must stay low
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("fs_to_ds_valid in reset", fs_to_ds_bus_t'(fs_to_ds_valid), '0);
        @(posedge clk);
        reset      <= 1'b0;
        ds_allowin <= 1'b1;

        // plain sequential stream from bfc00000
        run_traffic(12, 0, 0);
        // random in-window branches
        run_traffic(40, 0, 15);

        // misaligned target, then out of the window, each followed by a way back
        redirect_to(`IMEM_BASE + 32'h12, 1'b0);
        redirect_to(`IMEM_BASE + 32'h40, 1'b0);
        redirect_to(32'h8000_0000, 1'b0);
        redirect_to(`IMEM_BASE + 32'h08, 1'b0);

        // stall stretches only
        run_traffic(28, 30, 0);
        // stalls mixed with branches
        run_traffic(40, 25, 10);

        // flush to the vector, stay sequential there, then return
        redirect_to(`EXC_VECTOR, 1'b1);
        run_traffic(4, 20, 0);
        redirect_to(`IMEM_BASE, 1'b0);
        run_traffic(10, 20, 0);

        $display("Test OK");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/pre_if_stage.sv
source/if_stage.sv
source/inst_sram.sv
source/fetch_unit.sv
bench/fetch_unit_tb.sv

//--- source/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// pre-fetch to fetch bus: ex bit plus five code bits
`define PS_TO_FS_BUS_WD 6
// branch bus: taken bit on top of a 32-bit target
`define BR_BUS_WD 33
// fetch to decode bus: ex, code, bd, inst, pc
`define FS_TO_DS_BUS_WD 71

// first sequential pc lands on bfc00000
`define RESET_PC 32'hbfbffffc
`define EXC_VECTOR 32'hbfc00380

// instruction window, depth counted in words
`define IMEM_BASE 32'hbfc00000
`define IMEM_DEPTH 32

// cp0 exception codes
`define EXC_ADEL 5'd4
`define EXC_IBE 5'd6

`endif

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          ds_allowin,
    input  br_bus_t       br_bus,
    input  logic          fs_bd,
    input  logic          flush,
    output logic          fs_to_ds_valid,
    output fs_to_ds_bus_t fs_to_ds_bus
);

    // pre-fetch to fetch
    addr_t         ps_to_fs_nextpc;
    ps_to_fs_bus_t ps_to_fs_bus;

    // fetch back to pre-fetch
    addr_t         fs_pc;
    logic          fs_allowin;

    // memory side
    logic          inst_req;
    addr_t         inst_addr;
    logic          inst_data_ok;
    word_t         inst_rdata;

    pre_if_stage u_pre_if_stage (
        .clk             (clk),
        .reset           (reset),
        .fs_pc           (fs_pc),
        .fs_allowin      (fs_allowin),
        .br_bus          (br_bus),
        .flush           (flush),
        .inst_data_ok    (inst_data_ok),
        .ps_to_fs_nextpc (ps_to_fs_nextpc),
        .ps_to_fs_bus    (ps_to_fs_bus),
        .inst_req        (inst_req),
        .inst_addr       (inst_addr)
    );

    if_stage u_if_stage (
        .clk             (clk),
        .reset           (reset),
        .ps_to_fs_nextpc (ps_to_fs_nextpc),
        .ps_to_fs_bus    (ps_to_fs_bus),
        .fs_pc           (fs_pc),
        .fs_allowin      (fs_allowin),
        .ds_allowin      (ds_allowin),
        .fs_bd           (fs_bd),
        .flush           (flush),
        .inst_data_ok    (inst_data_ok),
        .inst_rdata      (inst_rdata),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds_bus    (fs_to_ds_bus)
    );

    // stands in for the icache
    inst_sram u_inst_sram (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata)
    );

endmodule

//--- source/if_stage.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module if_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  addr_t         ps_to_fs_nextpc,
    input  ps_to_fs_bus_t ps_to_fs_bus,
    output addr_t         fs_pc,
    output logic          fs_allowin,
    input  logic          ds_allowin,
    input  logic          fs_bd,
    input  logic          flush,
    input  logic          inst_data_ok,
    input  word_t         inst_rdata,
    output logic          fs_to_ds_valid,
    output fs_to_ds_bus_t fs_to_ds_bus
);

    ps_to_fs_bus_t ps_to_fs_bus_r;
    logic          ps_ex;
    exc_code_t     ps_code;
    logic          bypass;
    logic          advance;
    logic          adel_ex;
    logic          pc_in_window;
    logic          bad_pc;
    logic          fs_ex;
    exc_code_t     fs_code;
    word_t         fs_inst;

    // flush always lets the redirect through
    assign fs_allowin = flush ? 1'b1 : ds_allowin;

    // misaligned or out-of-window nextpc skips the memory
    assign bypass  = (ps_to_fs_nextpc[1:0] != 2'b00) | ps_to_fs_bus[`PS_TO_FS_BUS_WD-1];
    assign advance = fs_allowin & (inst_data_ok | bypass);

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= `RESET_PC;
        end else if (advance) begin
            fs_pc <= ps_to_fs_nextpc;
        end
    end

    // pre-fetch exception follows its pc
    always_ff @(posedge clk) begin
        if (reset) begin
            ps_to_fs_bus_r <= '0;
        end else if (advance) begin
            ps_to_fs_bus_r <= ps_to_fs_bus;
        end
    end

    // held under back-pressure, dropped while memory still waits
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_to_ds_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_to_ds_valid <= advance;
        end
    end

    assign {ps_ex, ps_code} = ps_to_fs_bus_r;

    assign adel_ex      = fs_pc[1:0] != 2'b00;
    assign pc_in_window = addr_in_window(fs_pc);
    assign bad_pc       = adel_ex | ~pc_in_window;

    // AdEL wins over the bus error code
    assign fs_ex   = adel_ex | ps_ex;
    assign fs_code = adel_ex ? `EXC_ADEL : ps_code;

    // rdata is stale for these, so hand decode a nop
    assign fs_inst = (flush | bad_pc) ? 32'd0 : inst_rdata;

    assign fs_to_ds_bus = {
        fs_ex,
        fs_code,
        fs_bd,
        fs_inst,
        fs_pc
    };

endmodule

//--- source/imem_init.hex
// one 32-bit instruction word per line, hex
// line n holds the word at bfc00000 + 4*n
3c1dbfc1
27bdfff0
24080001
24090002
01095020
3c0bbfc0
356b0100
8d6c0000
254a0001
11880003
ad6a0004
24020005
24030006
00432021
00832822
00a43024
00c53825
00e64026
3c04a000
ac820010
8c830010
1460fffd
03e00008
240a0007
2529ffff
01284823
000a5080
000b5842
316cffff
40806000
08300000
42000018

//--- source/inst_sram.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_sram
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_req,
    input  addr_t inst_addr,
    output logic  inst_data_ok,
    output word_t inst_rdata
);

    localparam int IDX_W = $clog2(`IMEM_DEPTH);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } state_t;

    state_t           state;
    logic [1:0]       wait_cnt;
    logic [7:0]       lfsr;
    addr_t            word_off;
    logic [IDX_W-1:0] word_idx;
    word_t            mem [0:`IMEM_DEPTH-1];

    initial begin
        $readmemh("source/imem_init.hex", mem);
    end

    // free-running lfsr, x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 8'h5a;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // a zero draw accepts in the request cycle itself
    assign inst_data_ok = inst_req &
        ((state == S_IDLE && lfsr[1:0] == 2'd0) || (state == S_WAIT && wait_cnt == 2'd0));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            wait_cnt <= 2'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    // new request, draw the wait
                    if (inst_req && lfsr[1:0] != 2'd0) begin
                        state    <= S_WAIT;
                        wait_cnt <= lfsr[1:0] - 2'd1;
                    end
                end
                S_WAIT: begin
                    if (inst_data_ok) begin
                        state <= S_IDLE;
                    end else if (wait_cnt != 2'd0) begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word index from the offset into the window
    assign word_off = inst_addr - `IMEM_BASE;
    assign word_idx = word_off[IDX_W+1:2];

    // held until the next acceptance
    always_ff @(posedge clk) begin
        if (inst_data_ok) begin
            inst_rdata <= mem[word_idx];
        end
    end

endmodule

//--- source/isa_pkg.sv
`include "fetch_consts.svh"

package isa_pkg;

    // instruction word as fetched
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // cp0 excode field
    typedef logic [4:0] exc_code_t;

    // true when the byte address falls inside the instruction window
    // unsigned wrap makes addresses below the base fail as well
    function automatic logic addr_in_window(addr_t addr);
        addr_t offset;
        offset = addr - `IMEM_BASE;
        return offset < 32'(`IMEM_DEPTH * 4);
    endfunction

endpackage

//--- source/pipe_pkg.sv
`include "fetch_consts.svh"

package pipe_pkg;

    // {ex, code} from pre-fetch
    typedef logic [`PS_TO_FS_BUS_WD-1:0] ps_to_fs_bus_t;

    // {taken, target} from decode
    // taken bit sits at the top
    typedef logic [`BR_BUS_WD-1:0] br_bus_t;

    // toward decode, top to bottom
    //   [70]    ex
    //   [69:65] excode
    //   [64]    branch delay slot
    //   [63:32] instruction
    //   [31:0]  pc
    typedef logic [`FS_TO_DS_BUS_WD-1:0] fs_to_ds_bus_t;

endpackage

//--- source/pre_if_stage.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pre_if_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  addr_t         fs_pc,
    input  logic          fs_allowin,
    input  br_bus_t       br_bus,
    input  logic          flush,
    input  logic          inst_data_ok,
    output addr_t         ps_to_fs_nextpc,
    output ps_to_fs_bus_t ps_to_fs_bus,
    output logic          inst_req,
    output addr_t         inst_addr
);

    logic      br_taken;
    addr_t     br_target;
    addr_t     seq_pc;
    logic      redirect;
    logic      pend_valid;
    addr_t     pend_pc;
    logic      aligned;
    logic      in_window;
    logic      req_ok;
    logic      advance;
    logic      ps_ex;
    exc_code_t ps_code;

    assign {br_taken, br_target} = br_bus;
    assign seq_pc   = fs_pc + 32'd4;
    assign redirect = flush | br_taken;

    // flush beats branch, branch beats a stored redirect
    always_comb begin
        if (flush) begin
            ps_to_fs_nextpc = `EXC_VECTOR;
        end else if (br_taken) begin
            ps_to_fs_nextpc = br_target;
        end else if (pend_valid) begin
            ps_to_fs_nextpc = pend_pc;
        end else begin
            ps_to_fs_nextpc = seq_pc;
        end
    end

    assign aligned   = ps_to_fs_nextpc[1:0] == 2'b00;
    assign in_window = addr_in_window(ps_to_fs_nextpc);
    assign req_ok    = aligned & in_window;

    // aligned but outside the window, bus error on fetch
    assign ps_ex        = aligned & ~in_window;
    assign ps_code      = ps_ex ? `EXC_IBE : 5'd0;
    assign ps_to_fs_bus = {ps_ex, ps_code};

    // bad addresses never reach memory
    assign inst_req  = fs_allowin & req_ok;
    assign inst_addr = ps_to_fs_nextpc;

    // same condition the fetch stage uses to take nextpc
    assign advance = fs_allowin & (inst_data_ok | ~req_ok);

    // remember a redirect seen while the request still waits
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (advance) begin
            pend_valid <= 1'b0;
        end else if (redirect) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect && !advance) begin
            pend_pc <= ps_to_fs_nextpc;
        end
    end

endmodule
